/* sram_pkg.sv */
package sram_pkg;

    // external ZBT SRAM geometry
    localparam int addr_w = 20;
    localparam int word_w = 18;

    // recorded sample width, stored as two byte lanes
    localparam int sample_w = 16;

    // edge accepting a read in the port up to the edge registering sample_out
    localparam int read_latency = 4;

    // play_start sample edge to first sample_out valid
    localparam int play_start_latency = 1 + read_latency;

    // one SRAM word, two even-parity byte lanes
    typedef struct packed {
        logic                      hi_parity;
        logic [sample_w/2-1:0]     hi_byte;
        logic                      lo_parity;
        logic [sample_w/2-1:0]     lo_byte;
    } sram_word_t;

    // single-cycle memory request from the writer
    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [addr_w-1:0]         addr;
        sram_word_t                wdata;
    } mem_req_t;

    // played back sample
    typedef struct packed {
        logic                      valid;
        logic                      parity_error;
        logic [sample_w-1:0]       data;
    } sample_out_t;

endpackage

/* capture_writer.sv */
`timescale 1ns/1ps

module capture_writer
    import sram_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_valid,
    input  logic [sample_w-1:0] sample_data,
    input  logic                play_start,
    input  logic [addr_w-1:0]   play_count,
    output mem_req_t            req,
    output logic                busy,
    output logic [addr_w-1:0]   rec_count
);

    // next playback address and end of the playback range
    logic [addr_w-1:0] rd_addr;
    logic [addr_w-1:0] play_end;
    sram_word_t        wr_word;

    // even parity per lane, byte ^ parity == 0
    always_comb begin
        wr_word.hi_byte   = sample_data[sample_w-1:sample_w/2];
        wr_word.lo_byte   = sample_data[sample_w/2-1:0];
        wr_word.hi_parity = ^wr_word.hi_byte;
        wr_word.lo_parity = ^wr_word.lo_byte;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
            req.write <= 1'b0;
            busy      <= 1'b0;
            rec_count <= '0;
            rd_addr   <= '0;
            play_end  <= '0;
        end else begin
            req.valid <= 1'b0;
            req.write <= 1'b0;
            if (busy) begin
                // back-to-back reads, one per cycle
                req.valid <= 1'b1;
                req.addr  <= rd_addr;
                rd_addr   <= rd_addr + 1'b1;
                if (rd_addr + 1'b1 == play_end) begin
                    busy <= 1'b0;
                end
            end else if (play_start && play_count != '0) begin
                // first read goes out right away
                req.valid <= 1'b1;
                req.addr  <= '0;
                rd_addr   <= addr_w'(1);
                play_end  <= play_count;
                busy      <= (play_count != addr_w'(1));
            end else if (sample_valid) begin
                req.valid <= 1'b1;
                req.write <= 1'b1;
                req.addr  <= rec_count;
                req.wdata <= wr_word;
                rec_count <= rec_count + 1'b1;
            end
        end
    end

    // a request must always carry a known address
    assert property (@(posedge clk) disable iff (reset)
        req.valid |-> !$isunknown(req.addr))
        else $error("request issued with unknown address");

endmodule

/* zbt_sram_port.sv */
`timescale 1ns/1ps

module zbt_sram_port
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  mem_req_t          req,
    output logic [addr_w-1:0] sram_addr,
    output logic              sram_we_n,
    output sram_word_t        dq_out,
    output logic              dq_oe,
    input  sram_word_t        dq_in,
    output sram_word_t        rd_word,
    output logic              sram_adv_ld,
    output logic [2:0]        sram_ce,
    output logic [1:0]        sram_bw_n,
    output logic              sram_oe_n,
    output logic              sram_cke_n,
    output logic              sram_clk
);

    // rising edge latches
    logic [addr_w-1:0] addr_latch;
    logic              we_latch;
    sram_word_t        data_latch;

    // falling edge hold and data-phase alignment
    logic [addr_w-1:0] addr_hold;
    logic              we_wait_1;
    logic              we_wait_2;
    logic              we_hold;
    sram_word_t        data_wait_1;
    sram_word_t        data_wait_2;
    sram_word_t        data_hold;

    // single-word access, always selected, all bytes written
    assign sram_adv_ld = 1'b0;
    assign sram_ce     = 3'b010;
    assign sram_bw_n   = 2'b00;
    assign sram_oe_n   = 1'b0;
    assign sram_cke_n  = 1'b0;
    assign sram_clk    = clk;

    always_ff @(posedge clk) begin
        if (reset) begin
            we_latch <= 1'b0;
        end else begin
            we_latch <= req.valid && req.write;
        end
        addr_latch <= req.addr;
        data_latch <= req.wdata;
        // read data returns two cycles after the address phase
        rd_word    <= dq_in;
    end

    // launch on the falling edge, write data trails by two cycles
    always_ff @(negedge clk) begin
        if (reset) begin
            we_wait_1 <= 1'b0;
            we_wait_2 <= 1'b0;
            we_hold   <= 1'b0;
        end else begin
            we_wait_1 <= we_latch;
            we_wait_2 <= we_wait_1;
            we_hold   <= we_wait_2;
        end
        addr_hold   <= addr_latch;
        data_wait_1 <= data_latch;
        data_wait_2 <= data_wait_1;
        data_hold   <= data_wait_2;
    end

    assign sram_addr = addr_hold;
    assign sram_we_n = ~we_wait_1;
    assign dq_out    = data_hold;
    assign dq_oe     = we_hold;

    // bus is only driven in the data phase of a launched write
    assert property (@(posedge clk) disable iff (reset)
        dq_oe |-> $past(!sram_we_n, 2))
        else $error("data bus driven without a write launch");

endmodule

/* playback_reader.sv */
`timescale 1ns/1ps

module playback_reader
    import sram_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  mem_req_t    req,
    input  sram_word_t  rd_word,
    output sample_out_t sample_out
);

    // request markers, index k loaded k edges after the port accepted it
    logic [read_latency-1:0] rd_pipe;
    logic [read_latency-1:0] wr_pipe;
    logic                    hi_bad;
    logic                    lo_bad;

    // even parity, lane xor must be zero
    assign hi_bad = ^{rd_word.hi_parity, rd_word.hi_byte};
    assign lo_bad = ^{rd_word.lo_parity, rd_word.lo_byte};

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pipe          <= '0;
            wr_pipe          <= '0;
            sample_out.valid <= 1'b0;
        end else begin
            rd_pipe          <= {rd_pipe[read_latency-2:0], req.valid && !req.write};
            wr_pipe          <= {wr_pipe[read_latency-2:0], req.valid && req.write};
            sample_out.valid <= rd_pipe[read_latency-1];
        end
        // rd_word holds the returned word while the last marker is up
        if (rd_pipe[read_latency-1]) begin
            sample_out.data         <= {rd_word.hi_byte, rd_word.lo_byte};
            sample_out.parity_error <= hi_bad || lo_bad;
        end
    end

    // a write directly ahead of a read still drives the bus as read data returns
    assert property (@(posedge clk) disable iff (reset)
        rd_pipe[read_latency-2] |-> !wr_pipe[read_latency-1])
        else $error("read return collides with write data phase");

endmodule

/* sample_recorder.sv */
`timescale 1ns/1ps

module sample_recorder
    import sram_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_valid,
    input  logic [sample_w-1:0] sample_data,
    input  logic                play_start,
    input  logic [addr_w-1:0]   play_count,
    output logic                busy,
    output logic [addr_w-1:0]   rec_count,
    output sample_out_t         sample_out,
    output logic [addr_w-1:0]   sram_addr,
    output logic                sram_we_n,
    output sram_word_t          dq_out,
    output logic                dq_oe,
    input  sram_word_t          dq_in,
    output logic                sram_adv_ld,
    output logic [2:0]          sram_ce,
    output logic [1:0]          sram_bw_n,
    output logic                sram_oe_n,
    output logic                sram_cke_n,
    output logic                sram_clk
);

    mem_req_t   req;
    sram_word_t rd_word;

    capture_writer capture_writer_i (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .play_start   (play_start),
        .play_count   (play_count),
        .req          (req),
        .busy         (busy),
        .rec_count    (rec_count)
    );

    // dq is split into out, enable and in, the pad ring joins them
    zbt_sram_port zbt_sram_port_i (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .sram_addr   (sram_addr),
        .sram_we_n   (sram_we_n),
        .dq_out      (dq_out),
        .dq_oe       (dq_oe),
        .dq_in       (dq_in),
        .rd_word     (rd_word),
        .sram_adv_ld (sram_adv_ld),
        .sram_ce     (sram_ce),
        .sram_bw_n   (sram_bw_n),
        .sram_oe_n   (sram_oe_n),
        .sram_cke_n  (sram_cke_n),
        .sram_clk    (sram_clk)
    );

    playback_reader playback_reader_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .rd_word    (rd_word),
        .sample_out (sample_out)
    );

endmodule

/* zbt_sram_model.sv */
`timescale 1ns/1ps

module zbt_sram_model
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic [addr_w-1:0] sram_addr,
    input  logic              sram_we_n,
    input  sram_word_t        dq_out,
    input  logic              dq_oe,
    output sram_word_t        dq_in,
    input  logic              sram_adv_ld,
    input  logic [2:0]        sram_ce,
    input  logic [1:0]        sram_bw_n,
    input  logic              sram_oe_n,
    input  logic              sram_cke_n,
    input  logic              fault_en,
    input  logic [addr_w-1:0] fault_addr
);

    // sparse storage, only written addresses exist
    sram_word_t mem [logic [addr_w-1:0]];

    // address phase and data phase pipeline
    logic              rd_s1 = 1'b0;
    logic              wr_s1 = 1'b0;
    logic              wr_s2 = 1'b0;
    logic [addr_w-1:0] addr_s1 = '0;
    logic [addr_w-1:0] addr_s2 = '0;
    sram_word_t        rdata = '0;
    logic              selected;

    assign selected = (sram_ce == 3'b010) && !sram_adv_ld && !sram_cke_n;
    // outputs float while the output enable is off
    assign dq_in    = sram_oe_n ? 'x : rdata;

    function automatic sram_word_t read_word(logic [addr_w-1:0] a);
        sram_word_t w;
        w = mem.exists(a) ? mem[a] : '0;
        // one weak cell, flips the lowest data bit
        if (fault_en && a == fault_addr) begin
            w.lo_byte[0] = ~w.lo_byte[0];
        end
        return w;
    endfunction

    always @(posedge clk) begin
        // write data sits on the bus two edges after its address
        if (wr_s2 && dq_oe) begin
            mem[addr_s2] = dq_out;
        end
        // read word is driven one edge after the address was taken
        if (rd_s1) begin
            rdata <= read_word(addr_s1);
        end
        wr_s2   <= wr_s1;
        addr_s2 <= addr_s1;
        rd_s1   <= selected && sram_we_n;
        // only full-word writes are modelled
        wr_s1   <= selected && !sram_we_n && (sram_bw_n == 2'b00);
        addr_s1 <= sram_addr;
    end

endmodule

/* tb_sample_recorder.sv */
`timescale 1ns/1ps

module tb_sample_recorder
    import sram_pkg::*;
();

    localparam int num_samples = 64;
    localparam int fault_index = 10;
    // reset, recording with gaps and three playbacks take about 400 cycles
    localparam int test_cycles    = 400;
    localparam int timeout_cycles = 5 * test_cycles;

    logic                clk;
    logic                reset;
    logic                sample_valid;
    logic [sample_w-1:0] sample_data;
    logic                play_start;
    logic [addr_w-1:0]   play_count;
    logic                busy;
    logic [addr_w-1:0]   rec_count;
    sample_out_t         sample_out;
    logic [addr_w-1:0]   sram_addr;
    logic                sram_we_n;
    sram_word_t          dq_out;
    logic                dq_oe;
    sram_word_t          dq_in;
    logic                sram_adv_ld;
    logic [2:0]          sram_ce;
    logic [1:0]          sram_bw_n;
    logic                sram_oe_n;
    logic                sram_cke_n;
    logic                sram_clk;
    logic                fault_en;
    logic [addr_w-1:0]   fault_addr;

    // recorded samples in address order
    logic [sample_w-1:0] recorded[$];
    logic [31:0]         rng_state;
    int                  cycle_count = 0;
    int                  rx_count = 0;
    int                  play_first = 0;
    int                  play_total = 0;
    int                  play_edge = 0;

    sample_recorder sample_recorder_i (.*);

    zbt_sram_model zbt_sram_model_i (.clk(sram_clk), .*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("no result after %0d cycles", cycle_count);
            abort_run("simulation timed out");
        end
    end

    task automatic abort_run(string reason);
        $display("Done: errors found");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_sample(sample_out_t actual, sample_out_t expected, string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got valid %b err %b data %h, want %b %b %h",
                     $time, what, actual.valid, actual.parity_error, actual.data,
                     expected.valid, expected.parity_error, expected.data);
            abort_run("sample mismatch");
        end
    endtask

    task automatic check_count(logic [addr_w-1:0] actual, logic [addr_w-1:0] expected,
                               string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            abort_run("count mismatch");
        end
    endtask

    task automatic check_bit(logic actual, logic expected, string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %b, expected %b",
                     $time, what, actual, expected);
            abort_run("flag mismatch");
        end
    endtask

    task automatic check_cycle(int actual, int expected, string what);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s, got cycle %0d, expected cycle %0d",
                     $time, what, actual, expected);
            abort_run("timing mismatch");
        end
    endtask

    function automatic logic [31:0] next_random(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // playback index equals the SRAM address
    function automatic sample_out_t expected_sample(int idx);
        sample_out_t exp_s;
        exp_s.valid        = 1'b1;
        exp_s.parity_error = 1'b0;
        exp_s.data         = recorded[idx];
        if (fault_en && addr_w'(idx) == fault_addr) begin
            // flipped bit breaks the low lane parity
            exp_s.data[0]      = ~exp_s.data[0];
            exp_s.parity_error = 1'b1;
        end
        return exp_s;
    endfunction

    always @(negedge clk) begin
        if (!reset && sample_out.valid) begin
            if (rx_count >= play_first + play_total) begin
                $display("sample_out valid at %0t with no sample outstanding", $time);
                abort_run("unexpected sample");
            end
            check_cycle(cycle_count, play_edge + play_start_latency + (rx_count - play_first),
                        "sample arrival");
            check_sample(sample_out, expected_sample(rx_count - play_first),
                         $sformatf("playback index %0d", rx_count - play_first));
            rx_count = rx_count + 1;
        end
    end

    task automatic record_samples(int count);
        for (int i = 0; i < count; i++) begin
            rng_state    = next_random(rng_state);
            sample_valid = 1'b1;
            sample_data  = rng_state[sample_w-1:0];
            recorded.push_back(rng_state[sample_w-1:0]);
            @(negedge clk);
            sample_valid = 1'b0;
            // zero to three idle cycles
            repeat (int'(rng_state[17:16])) @(negedge clk);
        end
    endtask

    task automatic run_playback(int count);
        play_first = rx_count;
        play_total = count;
        play_edge  = cycle_count + 1;
        play_start = 1'b1;
        play_count = addr_w'(count);
        @(negedge clk);
        play_start = 1'b0;
    endtask

    task automatic finish_playback();
        wait (rx_count == play_first + play_total);
        // an extra sample would show up within the read latency
        repeat (read_latency + 2) @(negedge clk);
        check_bit(busy, 1'b0, "busy after playback");
    endtask

    initial begin
        reset        = 1'b1;
        sample_valid = 1'b0;
        sample_data  = '0;
        play_start   = 1'b0;
        play_count   = '0;
        fault_en     = 1'b0;
        fault_addr   = '0;
        rng_state    = 32'd85522;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_bit(sample_out.valid, 1'b0, "sample_out valid after reset");
        check_bit(busy, 1'b0, "busy after reset");
        check_count(rec_count, '0, "rec_count after reset");

        record_samples(num_samples);
        check_count(rec_count, addr_w'(num_samples), "rec_count after recording");
        // let the last write reach the SRAM
        repeat (4) @(negedge clk);

        run_playback(num_samples);
        finish_playback();

        fault_en   = 1'b1;
        fault_addr = addr_w'(fault_index);
        run_playback(num_samples);
        finish_playback();
        fault_en = 1'b0;

        // strobes and a restart while busy
        run_playback(num_samples);
        repeat (2) @(negedge clk);
        check_bit(busy, 1'b1, "busy during playback");
        for (int i = 0; i < 8; i++) begin
            rng_state    = next_random(rng_state);
            sample_valid = 1'b1;
            sample_data  = rng_state[sample_w-1:0];
            play_start   = (i == 4);
            play_count   = addr_w'(5);
            @(negedge clk);
        end
        sample_valid = 1'b0;
        play_start   = 1'b0;
        finish_playback();
        check_count(rec_count, addr_w'(num_samples), "rec_count after ignored strobes");

        $display("Done: no errors");
        $finish;
    end

endmodule

/* tb.f */
sram_pkg.sv
capture_writer.sv
zbt_sram_port.sv
playback_reader.sv
sample_recorder.sv
zbt_sram_model.sv
tb_sample_recorder.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_sample_recorder \
    -f tb.f \
    -o sim_sample_recorder

./obj_dir/sim_sample_recorder
